// File: Bender.yml
package:
  name: regfile_alu

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - ram.sv
      - operand_fetch.sv
      - alu_exec.sv
      - regfile_alu.sv
  - target: test
    files:
      - tb_regfile_alu.sv

// File: alu_exec.sv
// ########################################
// execute stage
// alu, result hold and register writeback
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "stddef.svh"

module alu_exec (
	input logic								clk,
	input logic								rst,
	// issue from fetch
	input logic								iss_valid,
	output logic							iss_ready,
	input pipe_pkg::issue_t					iss,
	// result output
	output logic							out_valid,
	input logic								out_ready,
	output pipe_pkg::result_t				out_result,
	// held result, seen by fetch for forwarding
	output logic							pend_valid,
	output pipe_pkg::result_t				pend,
	// register file write port
	output logic							rf_wen_,
	output logic [isa_pkg::REG_W-1:0]		rf_waddr,
	output logic [isa_pkg::XLEN-1:0]		rf_wdata
);

	logic							res_valid_q;
	pipe_pkg::result_t				res_q;

	logic							iss_xfer;
	logic							out_xfer;
	logic [isa_pkg::XLEN-1:0]		alu_out;
	logic [isa_pkg::SHAMT_W-1:0]	shamt;

	assign iss_xfer = iss_valid && iss_ready;
	assign out_xfer = res_valid_q && out_ready;

	// empty, or the held result drains this edge
	assign iss_ready = !res_valid_q || out_ready;

	// shifts use the low bits of rs2
	assign shamt = iss.op_b[isa_pkg::SHAMT_W-1:0];

	always_comb begin
		case (iss.opcode)
			isa_pkg::ADD: alu_out = iss.op_a + iss.op_b;
			isa_pkg::SUB: alu_out = iss.op_a - iss.op_b;
			isa_pkg::AND: alu_out = iss.op_a & iss.op_b;
			isa_pkg::OR:  alu_out = iss.op_a | iss.op_b;
			isa_pkg::XOR: alu_out = iss.op_a ^ iss.op_b;
			isa_pkg::SLL: alu_out = iss.op_a << shamt;
			// logical, zero fill
			isa_pkg::SRL: alu_out = iss.op_a >> shamt;
			isa_pkg::LI:  alu_out = iss.imm;
			default:      alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid_q <= 1'b0;
		end else if (iss_xfer) begin
			res_valid_q <= 1'b1;
		end else if (out_xfer) begin
			res_valid_q <= 1'b0;
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (iss_xfer) begin
			res_q.rd <= iss.rd;
			res_q.data <= alu_out;
		end
	end

	assign out_valid = res_valid_q;
	assign out_result = res_q;
	assign pend_valid = res_valid_q;
	assign pend = res_q;

	// commit only when the output is taken
	assign rf_wen_ = out_xfer ? `Enable_ : `Disable_;
	assign rf_waddr = res_q.rd;
	assign rf_wdata = res_q.data;

endmodule

`default_nettype wire

// File: isa_pkg.sv
// ########################################
// instruction set definitions
// widths, opcodes and instruction format
// ########################################

`default_nettype none

package isa_pkg;

	// register data width
	parameter int XLEN = 16;
	// architectural register count
	parameter int NUM_REGS = 8;
	// register index width
	parameter int REG_W = $clog2(NUM_REGS);
	// immediate field width
	parameter int IMM_W = 8;
	// shift amount taken from rs2
	parameter int SHAMT_W = $clog2(XLEN);

	// alu operations
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLL = 3'd5,
		SRL = 3'd6,
		// load of sign-extended imm
		LI  = 3'd7
	} opcode_e;

	// instruction word, 20 bits
	typedef struct packed {
		opcode_e			opcode;
		logic [REG_W-1:0]	rd;
		logic [REG_W-1:0]	rs1;
		logic [REG_W-1:0]	rs2;
		logic [IMM_W-1:0]	imm;
	} instr_t;

endpackage

`default_nettype wire

// File: operand_fetch.sv
// ########################################
// operand fetch stage
// reads sources, forwards the pending write
// holds one issued operation for exec
// ########################################

`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
	input logic										clk,
	input logic										rst,
	// instruction input
	input logic										in_valid,
	output logic									in_ready,
	input isa_pkg::instr_t							in_instr,
	// register file read ports 0 and 1
	output logic [1:0]								rf_en_,
	output logic [1:0][isa_pkg::REG_W-1:0]			rf_addr,
	input logic [1:0][isa_pkg::XLEN-1:0]			rf_rdata,
	// result held in exec, not yet in ram
	input logic										pend_valid,
	input pipe_pkg::result_t						pend,
	// issue to exec
	output logic									iss_valid,
	input logic										iss_ready,
	output pipe_pkg::issue_t						iss
);

	logic							iss_valid_q;
	pipe_pkg::issue_t				iss_q;
	// source indices of the held operation
	logic [isa_pkg::REG_W-1:0]		rs1_q;
	logic [isa_pkg::REG_W-1:0]		rs2_q;

	logic							in_xfer;
	logic							iss_xfer;
	logic [isa_pkg::XLEN-1:0]		fwd_a;
	logic [isa_pkg::XLEN-1:0]		fwd_b;
	logic [isa_pkg::XLEN-1:0]		imm_ext;

	assign in_xfer = in_valid && in_ready;
	assign iss_xfer = iss_valid_q && iss_ready;

	// free slot, or the held op leaves this edge
	assign in_ready = !iss_valid_q || iss_ready;

	// read both sources while an instruction is offered
	assign rf_en_ = {2{~in_valid}};
	assign rf_addr[0] = in_instr.rs1;
	assign rf_addr[1] = in_instr.rs2;

	// exec result overrides a stale ram value
	assign fwd_a = (pend_valid && (pend.rd == in_instr.rs1)) ? pend.data : rf_rdata[0];
	assign fwd_b = (pend_valid && (pend.rd == in_instr.rs2)) ? pend.data : rf_rdata[1];

	assign imm_ext = {{(isa_pkg::XLEN - isa_pkg::IMM_W){in_instr.imm[isa_pkg::IMM_W-1]}},
		in_instr.imm};

	always_ff @(posedge clk) begin
		if (rst) begin
			iss_valid_q <= 1'b0;
		end else if (in_xfer) begin
			iss_valid_q <= 1'b1;
		end else if (iss_xfer) begin
			iss_valid_q <= 1'b0;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (in_xfer) begin
			iss_q.opcode <= in_instr.opcode;
			iss_q.rd <= in_instr.rd;
			iss_q.op_a <= fwd_a;
			iss_q.op_b <= fwd_b;
			iss_q.imm <= imm_ext;
			rs1_q <= in_instr.rs1;
			rs2_q <= in_instr.rs2;
		end
	end

	// the op issued just ahead was still in this stage at read time
	// its result shows up on pend once it sits in exec
	always_comb begin
		iss = iss_q;
		if (pend_valid && (pend.rd == rs1_q)) begin
			iss.op_a = pend.data;
		end
		if (pend_valid && (pend.rd == rs2_q)) begin
			iss.op_b = pend.data;
		end
	end

	assign iss_valid = iss_valid_q;

endmodule

`default_nettype wire

// File: pipe_pkg.sv
// ########################################
// pipeline stage handoff types
// fetch to exec, and exec to output
// ########################################

`default_nettype none

package pipe_pkg;

	// issued operation with resolved operands
	typedef struct packed {
		isa_pkg::opcode_e				opcode;
		logic [isa_pkg::REG_W-1:0]		rd;
		logic [isa_pkg::XLEN-1:0]		op_a;
		logic [isa_pkg::XLEN-1:0]		op_b;
		// already sign-extended
		logic [isa_pkg::XLEN-1:0]		imm;
	} issue_t;

	// computed result, also the pending writeback
	typedef struct packed {
		logic [isa_pkg::REG_W-1:0]		rd;
		logic [isa_pkg::XLEN-1:0]		data;
	} result_t;

endpackage

`default_nettype wire

// File: ram.sv
// ########################################
// flip-flop ram with shared r/w ports
// active-low enable and r/w select per port
// optional registered read data
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "stddef.svh"

module ram #(
	parameter int DATA = 16,
	parameter int DEPTH = 4,
	parameter int PORT = 1,
	parameter bit OUTREG = `Disable,
	// address width follows depth
	localparam int ADDR = $clog2(DEPTH)
)(
	input logic							clk,
	input logic							rst,
	// access enable, active low
	input logic [PORT-1:0]				en_,
	// high reads, low writes
	input logic [PORT-1:0]				rw_,
	input logic [PORT-1:0][ADDR-1:0]	addr,
	input logic [PORT-1:0][DATA-1:0]	wdata,
	output logic [PORT-1:0][DATA-1:0]	rdata
);

	// per-port strobes, active low
	logic [PORT-1:0]	ren_;
	logic [PORT-1:0]	wen_;

	// storage array
	logic [DATA-1:0]	mem [DEPTH];

	assign ren_ = ~rw_ | en_;
	assign wen_ = rw_ | en_;

	generate
		if (OUTREG) begin : g_outreg
			// read data one cycle after the address
			always_ff @(posedge clk) begin
				if (rst == `Enable) begin
					rdata <= '0;
				end else begin
					for (int i = 0; i < PORT; i++) begin
						if (ren_[i] == `Enable_) begin
							rdata[i] <= mem[addr[i]];
						end else begin
							rdata[i] <= '0;
						end
					end
				end
			end
		end else begin : g_comb
			// same-cycle read, idle port gives zero
			always_comb begin
				for (int i = 0; i < PORT; i++) begin
					if (ren_[i] == `Enable_) begin
						rdata[i] = mem[addr[i]];
					end else begin
						rdata[i] = '0;
					end
				end
			end
		end
	endgenerate

	// writes, higher port wins on a shared address
	always_ff @(posedge clk) begin
		if (rst == `Enable) begin
			for (int j = 0; j < DEPTH; j++) begin
				mem[j] <= '0;
			end
		end else begin
			for (int i = 0; i < PORT; i++) begin
				if (wen_[i] == `Enable_) begin
					mem[addr[i]] <= wdata[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: regfile_alu.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
ram.sv
operand_fetch.sv
alu_exec.sv
regfile_alu.sv
tb_regfile_alu.sv

// File: regfile_alu.sv
// ########################################
// register file alu datapath, top level
// fetch and exec around a three-port ram
// ########################################

`timescale 1ns/1ps
`default_nettype none

module regfile_alu (
	input logic						clk,
	input logic						rst,
	// instruction input
	input logic						in_valid,
	output logic					in_ready,
	input isa_pkg::instr_t			in_instr,
	// result output
	output logic					out_valid,
	input logic						out_ready,
	output pipe_pkg::result_t		out_result
);

	// ram port bundle, 0 and 1 read, 2 writes
	logic [2:0]								rf_en_;
	logic [2:0]								rf_rw_;
	logic [2:0][isa_pkg::REG_W-1:0]			rf_addr;
	logic [2:0][isa_pkg::XLEN-1:0]			rf_wdata;
	logic [2:0][isa_pkg::XLEN-1:0]			rf_rdata;

	// fetch side read ports
	logic [1:0]								rd_en_;
	logic [1:0][isa_pkg::REG_W-1:0]			rd_addr;

	// exec side write port
	logic									wr_en_;
	logic [isa_pkg::REG_W-1:0]				wr_addr;
	logic [isa_pkg::XLEN-1:0]				wr_data;

	// stage handoff
	logic									iss_valid;
	logic									iss_ready;
	pipe_pkg::issue_t						iss;
	logic									pend_valid;
	pipe_pkg::result_t						pend;

	assign rf_en_ = {wr_en_, rd_en_};
	// rw_ high reads, low writes
	assign rf_rw_ = 3'b011;
	assign rf_addr = {wr_addr, rd_addr};
	// read ports carry no write data
	assign rf_wdata = {wr_data, {(2 * isa_pkg::XLEN){1'b0}}};

	// output register off, reads same cycle
	ram #(
		.DATA	(isa_pkg::XLEN),
		.DEPTH	(isa_pkg::NUM_REGS),
		.PORT	(3),
		.OUTREG	(1'b0)
	) u_ram (
		.clk	(clk),
		.rst	(rst),
		.en_	(rf_en_),
		.rw_	(rf_rw_),
		.addr	(rf_addr),
		.wdata	(rf_wdata),
		.rdata	(rf_rdata)
	);

	operand_fetch u_fetch (
		.clk		(clk),
		.rst		(rst),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_instr	(in_instr),
		.rf_en_		(rd_en_),
		.rf_addr	(rd_addr),
		.rf_rdata	(rf_rdata[1:0]),
		.pend_valid	(pend_valid),
		.pend		(pend),
		.iss_valid	(iss_valid),
		.iss_ready	(iss_ready),
		.iss		(iss)
	);

	alu_exec u_exec (
		.clk		(clk),
		.rst		(rst),
		.iss_valid	(iss_valid),
		.iss_ready	(iss_ready),
		.iss		(iss),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_result	(out_result),
		.pend_valid	(pend_valid),
		.pend		(pend),
		.rf_wen_	(wr_en_),
		.rf_waddr	(wr_addr),
		.rf_wdata	(wr_data)
	);

endmodule

`default_nettype wire

// File: regfile_alu_tests.txt
// hex columns: opcode rd rs1 rs2 imm exp_rd exp_data
// opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 li; ffff ends the stream
0 1 2 3 00 1 0000
7 1 0 0 7f 1 007f
7 2 0 0 80 2 ff80
0 3 1 2 00 3 ffff
1 4 3 1 00 4 ff80
0 5 4 4 00 5 ff00
2 6 5 1 00 6 0000
3 6 5 1 00 6 ff7f
4 7 6 3 a5 7 0080
7 0 0 0 13 0 0013
5 1 1 0 00 1 03f8
6 2 2 0 00 2 1ff0
7 0 0 0 f4 0 fff4
5 3 7 0 00 3 0800
6 4 3 0 00 4 0080
1 5 0 4 00 5 ff74
1 6 6 6 00 6 0000
0 6 6 5 00 6 ff74
4 7 7 7 00 7 0000
7 7 0 0 01 7 0001
5 7 7 7 00 7 0002
5 7 7 7 00 7 0008
3 1 7 2 00 1 1ff8
2 2 1 6 00 2 1f70
0 0 2 1 00 0 3f68
6 3 0 7 00 3 003f
1 4 3 0 00 4 c0d7
0 5 5 4 00 5 c04b
ffff

// File: stddef.svh
// ########################################
// common level definitions
// active-high and active-low enable levels
// ########################################

`ifndef STDDEF_SVH
`define STDDEF_SVH

// active-high levels
`define Enable		1'b1
`define Disable		1'b0

// active-low levels, used by signals ending in _
`define Enable_		1'b0
`define Disable_	1'b1

`endif

// File: tb_regfile_alu.sv
// ########################################
// testbench for the register file alu
// file driven stream with random back-pressure
// ########################################

`timescale 1ns/1ps
`default_nettype none

module tb_regfile_alu;

	localparam int MAX_TESTS = 64;
	// opcode rd rs1 rs2 imm exp_rd exp_data
	localparam int COLS = 7;
	localparam int IN_TIMEOUT = 64;
	localparam int OUT_TIMEOUT = 64;
	localparam int MAX_CYCLES = 5000;

	logic					clk;
	logic					rst;
	logic					in_valid;
	logic					in_ready;
	isa_pkg::instr_t		in_instr;
	logic					out_valid;
	logic					out_ready;
	pipe_pkg::result_t		out_result;

	logic [15:0]			vec [MAX_TESTS*COLS];
	pipe_pkg::result_t		exp_q [$];
	int						num_tests;
	int						num_checked;

	regfile_alu DUT (
		.clk		(clk),
		.rst		(rst),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_instr	(in_instr),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_result	(out_result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input string name, input pipe_pkg::result_t exp,
		input pipe_pkg::result_t act);
		if (act !== exp) begin
			report_failure($sformatf(
				"Fail at %0t ns: %s expected rd=%0d data=%h, got rd=%0d data=%h",
				$time, name, exp.rd, exp.data, act.rd, act.data));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("Fail at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
		end
	endtask

	// instruction fields of one file line
	function automatic isa_pkg::instr_t vector_instr(input int n);
		isa_pkg::instr_t instr;
		instr.opcode = isa_pkg::opcode_e'(vec[n*COLS][2:0]);
		instr.rd = vec[n*COLS+1][isa_pkg::REG_W-1:0];
		instr.rs1 = vec[n*COLS+2][isa_pkg::REG_W-1:0];
		instr.rs2 = vec[n*COLS+3][isa_pkg::REG_W-1:0];
		instr.imm = vec[n*COLS+4][isa_pkg::IMM_W-1:0];
		return instr;
	endfunction

	// expected output of one file line
	function automatic pipe_pkg::result_t vector_result(input int n);
		pipe_pkg::result_t res;
		res.rd = vec[n*COLS+5][isa_pkg::REG_W-1:0];
		res.data = vec[n*COLS+6];
		return res;
	endfunction

	initial begin
		int seed_val;
		int idx;
		int gap;
		int stall_left;
		int in_wait;
		int out_wait;
		int cycles;
		int r;
		bit accepted;
		seed_val = 32'hc019_679b;
		void'($urandom(seed_val));
		rst = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b0;
		// ffff in the opcode column ends the stream
		for (int i = 0; i < MAX_TESTS*COLS; i++) begin
			vec[i] = 16'hffff;
		end
		$readmemh("regfile_alu_tests.txt", vec);
		num_tests = 0;
		while (num_tests < MAX_TESTS && vec[num_tests*COLS] != 16'hffff) begin
			num_tests++;
		end
		if (num_tests == 0) begin
			report_failure("no instructions found in regfile_alu_tests.txt");
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		// idle pipeline after reset
		check_level("out_valid", 1'b0, out_valid);
		check_level("in_ready", 1'b1, in_ready);
		check_level("iss_valid", 1'b0, DUT.iss_valid);
		check_level("pend_valid", 1'b0, DUT.pend_valid);
		@(negedge clk);
		idx = 0;
		gap = 0;
		stall_left = 0;
		in_wait = 0;
		out_wait = 0;
		cycles = 0;
		accepted = 1'b0;
		num_checked = 0;
		while (num_checked < num_tests && cycles < MAX_CYCLES) begin
			// drop valid after a transfer, maybe offer the next one at once
			if (accepted) begin
				in_valid = 1'b0;
				accepted = 1'b0;
			end
			if (!in_valid && idx < num_tests) begin
				if (gap == 0) begin
					in_instr = vector_instr(idx);
					in_valid = 1'b1;
				end else begin
					gap--;
				end
			end
			// short stalls often, a long one now and then
			if (stall_left > 0) begin
				out_ready = 1'b0;
				stall_left--;
			end else begin
				r = $urandom % 16;
				if (r == 0) begin
					out_ready = 1'b0;
					stall_left = 8 + $urandom % 9;
				end else begin
					out_ready = (r > 4);
				end
			end
			// the next edge transfers what is seen here
			#1;
			if (out_valid) begin
				out_wait = 0;
				if (out_ready) begin
					if (exp_q.size() == 0) begin
						report_failure("result appeared with no instruction outstanding");
					end
					check_result("out_result", exp_q.pop_front(), out_result);
					num_checked++;
				end
			end else if (exp_q.size() > 0) begin
				out_wait++;
				if (out_wait > OUT_TIMEOUT) begin
					report_failure("timeout: out_valid never rose for an accepted instruction");
				end
			end
			if (in_valid) begin
				if (in_ready) begin
					exp_q.push_back(vector_result(idx));
					idx++;
					accepted = 1'b1;
					in_wait = 0;
					gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
				end else begin
					in_wait++;
					if (in_wait > IN_TIMEOUT) begin
						report_failure("timeout: in_ready never rose for the offered instruction");
					end
				end
			end
			cycles++;
			@(negedge clk);
		end
		if (num_checked == num_tests) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_failure("run ended before all results were seen");
		end
	end

endmodule

`default_nettype wire
